/* axil_pkg.sv */
`default_nettype none

package axil_pkg;

   // bus widths
   localparam int AXIL_ADDR_W = 64;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // response codes, only the two this slave returns
   typedef logic [1:0] axil_resp_t;

   localparam axil_resp_t RESP_OKAY   = 2'b00;
   localparam axil_resp_t RESP_SLVERR = 2'b10;

   // B channel payload
   typedef struct packed {
      axil_resp_t resp;
   } b_payload_t;

   // R channel payload, data in the upper bits
   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      axil_resp_t             resp;
   } r_payload_t;

endpackage

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

   // word geometry of the RAM
   localparam int BYTE_W     = 8;
   localparam int MEM_WORD_W = 32;
   localparam int MEM_STRB_W = MEM_WORD_W / BYTE_W;

   // address bits below the word index
   localparam int BYTE_OFFSET_W = $clog2(MEM_STRB_W);

   typedef logic [MEM_WORD_W-1:0] mem_word_t;
   typedef logic [MEM_STRB_W-1:0] mem_strb_t;

endpackage

`default_nettype wire

/* mem_port_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if #(
   parameter int INDEX_W = 8
);
   import mem_pkg::*;

   logic               en;
   logic               we;
   logic [INDEX_W-1:0] idx;
   mem_word_t          wdata;
   mem_strb_t          strb;
   // registered by the RAM, valid the cycle after en
   mem_word_t          rdata;

   modport master (
      output en,
      output we,
      output idx,
      output wdata,
      output strb,
      input  rdata
   );

   modport slave (
      input  en,
      input  we,
      input  idx,
      input  wdata,
      input  strb,
      output rdata
   );

endinterface

`default_nettype wire

/* axil_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_slave #(
   parameter int RAM_DEPTH   = 256,
   parameter int RAM_INDEX_W = 8
) (
   input  logic                             clk,
   input  logic                             rst_n,

   input  logic                             awvalid,
   input  logic [axil_pkg::AXIL_ADDR_W-1:0] awaddr,
   output logic                             awready,

   input  logic                             wvalid,
   input  logic [axil_pkg::AXIL_DATA_W-1:0] wdata,
   input  logic [axil_pkg::AXIL_STRB_W-1:0] wstrb,
   output logic                             wready,

   input  logic                             arvalid,
   input  logic [axil_pkg::AXIL_ADDR_W-1:0] araddr,
   output logic                             arready,

   output logic                             b_push_valid,
   output axil_pkg::b_payload_t             b_push_data,
   input  logic                             b_push_ready,

   output logic                             r_push_valid,
   output axil_pkg::r_payload_t             r_push_data,
   input  logic                             r_push_ready,

   mem_port_if.master                       wr_port,
   mem_port_if.master                       rd_port
);
   import axil_pkg::*;
   import mem_pkg::*;

   localparam int WORD_ADDR_W = AXIL_ADDR_W - BYTE_OFFSET_W;

   logic                   aw_hs;
   logic                   w_hs;
   logic                   ar_hs;
   logic                   r_push;

   logic                   wr_active;
   logic                   wr_in_range;
   logic [RAM_INDEX_W-1:0] wr_idx;

   logic                   rd_pending;
   logic                   rd_in_range;

   // word address compared against the RAM size, upper bits included
   function automatic logic addr_in_range(input logic [AXIL_ADDR_W-1:0] addr);
      return addr[AXIL_ADDR_W-1:BYTE_OFFSET_W] < WORD_ADDR_W'(RAM_DEPTH);
   endfunction

   function automatic logic [RAM_INDEX_W-1:0] addr_index(input logic [AXIL_ADDR_W-1:0] addr);
      return addr[BYTE_OFFSET_W +: RAM_INDEX_W];
   endfunction

   // write channel
   assign aw_hs        = awvalid && awready;
   assign wready       = wr_active && wvalid && b_push_ready;
   assign w_hs         = wvalid && wready;
   assign b_push_valid = wr_active && wvalid;

   // awready is registered so it stays low through reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_active <= 1'b0;
         awready   <= 1'b0;
      end
      else if (aw_hs)
      begin
         wr_active <= 1'b1;
         awready   <= 1'b0;
      end
      else if (w_hs)
      begin
         wr_active <= 1'b0;
         awready   <= 1'b1;
      end
      else
         awready <= !wr_active;
   end

   always_ff @(posedge clk)
   begin
      if (aw_hs)
      begin
         wr_idx      <= addr_index(awaddr);
         wr_in_range <= addr_in_range(awaddr);
      end
   end

   // out of range writes still answer, but leave the RAM alone
   assign wr_port.en    = w_hs && wr_in_range;
   assign wr_port.we    = w_hs && wr_in_range;
   assign wr_port.idx   = wr_idx;
   assign wr_port.wdata = wdata;
   assign wr_port.strb  = wstrb;

   assign b_push_data.resp = wr_in_range ? RESP_OKAY : RESP_SLVERR;

   // read channel
   // buffer space is checked here, the push one cycle later cannot stall
   assign arready      = !rd_pending && r_push_ready;
   assign ar_hs        = arvalid && arready;
   assign r_push_valid = rd_pending;
   assign r_push       = r_push_valid && r_push_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rd_pending <= 1'b0;
      else if (ar_hs)
         rd_pending <= 1'b1;
      else if (r_push)
         rd_pending <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (ar_hs)
         rd_in_range <= addr_in_range(araddr);
   end

   assign rd_port.en    = ar_hs && addr_in_range(araddr);
   assign rd_port.we    = 1'b0;
   assign rd_port.idx   = addr_index(araddr);
   assign rd_port.wdata = '0;
   assign rd_port.strb  = '0;

   assign r_push_data.data = rd_in_range ? rd_port.rdata : '0;
   assign r_push_data.resp = rd_in_range ? RESP_OKAY : RESP_SLVERR;

   // a W beat only after an accepted address, with aw held off meanwhile
   a_wready_in_write: assert property (@(posedge clk) disable iff (!rst_n)
      wready |-> wr_active && !awready);

   // one read in flight; its data reaches the buffer before the next access
   a_rd_single: assert property (@(posedge clk) disable iff (!rst_n)
      rd_port.en |=> rd_pending && !rd_port.en);

endmodule

`default_nettype wire

/* bram_2rw.sv */
`timescale 1ns/100ps
`default_nettype none

module bram_2rw #(
   parameter int RAM_DEPTH   = 256,
   parameter int RAM_INDEX_W = 8
) (
   input logic       clk,
   mem_port_if.slave a,
   mem_port_if.slave b
);
   import mem_pkg::*;

   mem_word_t mem [RAM_DEPTH];

   // the index must reach every word
   if (RAM_DEPTH > (1 << RAM_INDEX_W))
   begin : g_depth_check
      $error("bram_2rw: RAM_DEPTH exceeds the index range");
   end

   // port a: byte-enable write
   always_ff @(posedge clk)
   begin
      if (a.en)
      begin
         if (a.we)
         begin
            for (int i = 0; i < MEM_STRB_W; i++)
            begin
               if (a.strb[i])
                  mem[a.idx][BYTE_W*i +: BYTE_W] <= a.wdata[BYTE_W*i +: BYTE_W];
            end
         end
      end
   end

   // port b: read only, rdata holds until the next enable
   always_ff @(posedge clk)
   begin
      if (b.en)
         b.rdata <= mem[b.idx];
   end

   // the front end never writes through the read port
   a_b_read_only: assert property (@(posedge clk)
      b.en |-> !b.we);

endmodule

`default_nettype wire

/* axil_resp_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_resp_buffer #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     push_valid,
   input  payload_t push_data,
   output logic     push_ready,

   output logic     pop_valid,
   output payload_t pop_data,
   input  logic     pop_ready
);

   logic     push;
   logic     pop;
   logic     skid_valid;
   logic     pop_valid_next;
   logic     skid_valid_next;
   payload_t skid_data;

   assign push = push_valid && push_ready;
   assign pop  = pop_valid && pop_ready;

   // output register is the head, skid holds the second entry
   always_comb
   begin
      pop_valid_next  = pop_valid;
      skid_valid_next = skid_valid;
      if (pop && !skid_valid)
         pop_valid_next = push;
      else if (pop)
         skid_valid_next = push;
      else if (push && !pop_valid)
         pop_valid_next = 1'b1;
      else if (push)
         skid_valid_next = 1'b1;
   end

   // push_ready registered, low through reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pop_valid  <= 1'b0;
         skid_valid <= 1'b0;
         push_ready <= 1'b0;
      end
      else
      begin
         pop_valid  <= pop_valid_next;
         skid_valid <= skid_valid_next;
         push_ready <= !(pop_valid_next && skid_valid_next);
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop && skid_valid)
         pop_data <= skid_data;
      else if (push && (pop || !pop_valid))
         pop_data <= push_data;
      if (push && (pop ? skid_valid : pop_valid))
         skid_data <= push_data;
   end

   a_pop_stable: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

   // both entries taken, the producer must be held off
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid && skid_valid |-> !push);

endmodule

`default_nettype wire

/* axil_ram_top.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_ram_top #(
   parameter int RAM_DEPTH = 256
) (
   input  logic                             clk,
   input  logic                             rst_n,

   input  logic                             awvalid,
   input  logic [axil_pkg::AXIL_ADDR_W-1:0] awaddr,
   output logic                             awready,

   input  logic                             wvalid,
   input  logic [axil_pkg::AXIL_DATA_W-1:0] wdata,
   input  logic [axil_pkg::AXIL_STRB_W-1:0] wstrb,
   output logic                             wready,

   output logic                             bvalid,
   output axil_pkg::axil_resp_t             bresp,
   input  logic                             bready,

   input  logic                             arvalid,
   input  logic [axil_pkg::AXIL_ADDR_W-1:0] araddr,
   output logic                             arready,

   output logic                             rvalid,
   output logic [axil_pkg::AXIL_DATA_W-1:0] rdata,
   output axil_pkg::axil_resp_t             rresp,
   input  logic                             rready
);
   import axil_pkg::*;

   localparam int RAM_INDEX_W = $clog2(RAM_DEPTH);

   logic       b_push_valid;
   logic       b_push_ready;
   b_payload_t b_push_data;
   b_payload_t b_pop_data;

   logic       r_push_valid;
   logic       r_push_ready;
   r_payload_t r_push_data;
   r_payload_t r_pop_data;

   mem_port_if #(.INDEX_W(RAM_INDEX_W)) wr_port ();
   mem_port_if #(.INDEX_W(RAM_INDEX_W)) rd_port ();

   axil_slave #(
      .RAM_DEPTH   (RAM_DEPTH),
      .RAM_INDEX_W (RAM_INDEX_W)
   ) u_slave (
      .clk          (clk),
      .rst_n        (rst_n),
      .awvalid      (awvalid),
      .awaddr       (awaddr),
      .awready      (awready),
      .wvalid       (wvalid),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wready       (wready),
      .arvalid      (arvalid),
      .araddr       (araddr),
      .arready      (arready),
      .b_push_valid (b_push_valid),
      .b_push_data  (b_push_data),
      .b_push_ready (b_push_ready),
      .r_push_valid (r_push_valid),
      .r_push_data  (r_push_data),
      .r_push_ready (r_push_ready),
      .wr_port      (wr_port.master),
      .rd_port      (rd_port.master)
   );

   bram_2rw #(
      .RAM_DEPTH   (RAM_DEPTH),
      .RAM_INDEX_W (RAM_INDEX_W)
   ) u_ram (
      .clk (clk),
      .a   (wr_port.slave),
      .b   (rd_port.slave)
   );

   axil_resp_buffer #(
      .payload_t (b_payload_t)
   ) u_b_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (b_push_valid),
      .push_data  (b_push_data),
      .push_ready (b_push_ready),
      .pop_valid  (bvalid),
      .pop_data   (b_pop_data),
      .pop_ready  (bready)
   );

   axil_resp_buffer #(
      .payload_t (r_payload_t)
   ) u_r_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (r_push_valid),
      .push_data  (r_push_data),
      .push_ready (r_push_ready),
      .pop_valid  (rvalid),
      .pop_data   (r_pop_data),
      .pop_ready  (rready)
   );

   assign bresp = b_pop_data.resp;
   assign rdata = r_pop_data.data;
   assign rresp = r_pop_data.resp;

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // release a little after an edge, like the other inputs
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #10;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tb_axil_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_axil_ram;

   localparam int RAM_DEPTH      = 256;
   localparam int TIMEOUT_CYCLES = 4000;
   localparam logic [1:0] OKAY   = 2'b00;
   localparam logic [1:0] SLVERR = 2'b10;

   logic        clk;
   logic        rst_n;
   logic        awvalid;
   logic [63:0] awaddr;
   logic        awready;
   logic        wvalid;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wready;
   logic        bvalid;
   logic [1:0]  bresp;
   logic        bready;
   logic        arvalid;
   logic [63:0] araddr;
   logic        arready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rready;

   logic [31:0] model [RAM_DEPTH];
   int          errors;
   int          checks;
   int          test_start_errors;
   int          cycle_count;
   int unsigned seed_value;

   tb_clk_gen #(.PERIOD(100), .RESET_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

   axil_ram_top #(.RAM_DEPTH(RAM_DEPTH)) u_axil_ram_top (
      .clk(clk), .rst_n(rst_n),
      .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
      .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .arvalid(arvalid), .araddr(araddr), .arready(arready),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
   );

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("[FAIL] %0d ns: %s: got %h, expected %h", $time, msg, actual, expected);
      end
   endtask

   function automatic logic [63:0] byte_addr(input longint unsigned idx);
      return idx * 4;
   endfunction

   // expected word after a strobed write
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strb);
      logic [31:0] result;
      result = old_word;
      for (int i = 0; i < 4; i++)
         if (strb[i])
            result[8*i +: 8] = new_word[8*i +: 8];
      return result;
   endfunction

   task automatic next_drive_slot();
      @(posedge clk);
      #10;
   endtask

   // each channel task samples ready or valid at the falling edge
   task automatic send_aw(input logic [63:0] addr);
      awaddr  = addr;
      awvalid = 1'b1;
      @(negedge clk);
      while (!awready) @(negedge clk);
      next_drive_slot();
      awvalid = 1'b0;
   endtask

   task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
      wdata  = data;
      wstrb  = strb;
      wvalid = 1'b1;
      @(negedge clk);
      while (!wready) @(negedge clk);
      next_drive_slot();
      wvalid = 1'b0;
   endtask

   task automatic take_b(output logic [1:0] resp);
      bready = 1'b1;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      resp = bresp;
      next_drive_slot();
      bready = 1'b0;
   endtask

   task automatic send_ar(input logic [63:0] addr);
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      next_drive_slot();
      arvalid = 1'b0;
   endtask

   task automatic take_r(output logic [31:0] data, output logic [1:0] resp);
      rready = 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      data = rdata;
      resp = rresp;
      next_drive_slot();
      rready = 1'b0;
   endtask

   task automatic axil_write(input logic [63:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
      send_aw(addr);
      send_w(data, strb);
      take_b(resp);
   endtask

   task automatic axil_read(input logic [63:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      send_ar(addr);
      take_r(data, resp);
   endtask

   // write through the bus and keep the model in step
   task automatic write_ok(input int idx, input logic [31:0] data, input logic [3:0] strb);
      logic [1:0] resp;
      axil_write(byte_addr(idx), data, strb, resp);
      check_value(resp, OKAY, "write response");
      model[idx] = merge_bytes(model[idx], data, strb);
   endtask

   task automatic read_expect(input int idx);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(byte_addr(idx), data, resp);
      check_value(resp, OKAY, "read response");
      check_value(data, model[idx], $sformatf("read data at word %0d", idx));
   endtask

   task automatic finish_test(input string name);
      if (errors == test_start_errors)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - test_start_errors);
      test_start_errors = errors;
   endtask

   task automatic test_reset();
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value(awready, 1'b0, "awready in reset");
      check_value(wready, 1'b0, "wready in reset");
      check_value(arready, 1'b0, "arready in reset");
      check_value(bvalid, 1'b0, "bvalid in reset");
      check_value(rvalid, 1'b0, "rvalid in reset");
      @(posedge rst_n);
      // ready outputs rise at the first edge that sees reset released
      @(posedge clk);
      @(negedge clk);
      check_value(awready, 1'b1, "awready after reset");
      check_value(arready, 1'b1, "arready after reset");
      check_value(bvalid, 1'b0, "bvalid after reset");
      check_value(rvalid, 1'b0, "rvalid after reset");
      next_drive_slot();
      finish_test("reset");
   endtask

   task automatic test_random_rw();
      int idx_list [16];
      for (int i = 0; i < 16; i++)
      begin
         idx_list[i] = $urandom % RAM_DEPTH;
         write_ok(idx_list[i], $urandom, 4'hf);
      end
      for (int i = 0; i < 16; i++)
         read_expect(idx_list[i]);
      finish_test("random_rw");
   endtask

   task automatic test_partial_strobe();
      write_ok(200, 32'ha5a5_5a5a, 4'hf);
      for (int s = 1; s < 15; s++)
      begin
         write_ok(200, $urandom, 4'(s));
         read_expect(200);
      end
      finish_test("partial_strobe");
   endtask

   task automatic test_out_of_range();
      logic [31:0] data;
      logic [1:0]  resp;
      write_ok(17, 32'h1234_5678, 4'hf);
      // aliases of word 17 just above the RAM and in the upper address bits
      axil_write(byte_addr(RAM_DEPTH + 17), 32'hdead_beef, 4'hf, resp);
      check_value(resp, SLVERR, "out of range write response");
      axil_write(64'h1_0000_0000 + byte_addr(17), 32'hcafe_f00d, 4'hf, resp);
      check_value(resp, SLVERR, "high address write response");
      read_expect(17);
      axil_read(byte_addr(RAM_DEPTH + 5), data, resp);
      check_value(resp, SLVERR, "out of range read response");
      check_value(data, 32'h0, "out of range read data");
      axil_read(64'hffff_ffff_ffff_fffc, data, resp);
      check_value(resp, SLVERR, "top address read response");
      check_value(data, 32'h0, "top address read data");
      finish_test("out_of_range");
   endtask

   task automatic test_backpressure();
      logic [31:0] wr_data [3];
      logic [31:0] data;
      logic [1:0]  resp;
      for (int i = 0; i < 3; i++)
         wr_data[i] = $urandom;
      // two writes fill the B buffer while bready is low
      for (int i = 0; i < 2; i++)
      begin
         send_aw(byte_addr(40 + i));
         send_w(wr_data[i], 4'hf);
      end
      send_aw(byte_addr(42));
      wdata  = wr_data[2];
      wstrb  = 4'hf;
      wvalid = 1'b1;
      repeat (5)
      begin
         @(negedge clk);
         check_value(wready, 1'b0, "wready with B buffer full");
         check_value(bvalid, 1'b1, "bvalid while stalled");
         check_value(bresp, OKAY, "bresp while stalled");
      end
      next_drive_slot();
      take_b(resp);
      check_value(resp, OKAY, "first stalled write response");
      send_w(wr_data[2], 4'hf);
      for (int i = 0; i < 2; i++)
      begin
         take_b(resp);
         check_value(resp, OKAY, "queued write response");
      end
      for (int i = 0; i < 3; i++)
         model[40 + i] = wr_data[i];
      // now the same with reads and rready low
      send_ar(byte_addr(40));
      send_ar(byte_addr(41));
      araddr  = byte_addr(42);
      arvalid = 1'b1;
      repeat (5)
      begin
         @(negedge clk);
         check_value(arready, 1'b0, "arready with R buffer full");
         check_value(rvalid, 1'b1, "rvalid while stalled");
         check_value(rdata, model[40], "rdata while stalled");
      end
      next_drive_slot();
      for (int i = 0; i < 3; i++)
      begin
         if (i == 1)
            send_ar(byte_addr(42));
         take_r(data, resp);
         check_value(resp, OKAY, "queued read response");
         check_value(data, model[40 + i], "queued read data in order");
      end
      finish_test("backpressure");
   endtask

   task automatic test_delayed_wdata();
      logic [31:0] data;
      logic [1:0]  resp;
      data = $urandom;
      send_aw(byte_addr(99));
      repeat (4)
      begin
         @(negedge clk);
         check_value(wready, 1'b0, "wready before wvalid");
         check_value(awready, 1'b0, "awready during write");
      end
      next_drive_slot();
      send_w(data, 4'hf);
      take_b(resp);
      check_value(resp, OKAY, "delayed write response");
      model[99] = data;
      read_expect(99);
      finish_test("delayed_wdata");
   endtask

   initial
   begin
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      errors            = 0;
      checks            = 0;
      test_start_errors = 0;
      cycle_count       = 0;
      seed_value = $urandom(29);

      test_reset();
      test_random_rw();
      test_partial_strobe();
      test_out_of_range();
      test_backpressure();
      test_delayed_wdata();

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
axil_pkg.sv
mem_pkg.sv
mem_port_if.sv
axil_slave.sv
bram_2rw.sv
axil_resp_buffer.sv
axil_ram_top.sv
tb_clk_gen.sv
tb_axil_ram.sv

/* Bender.yml */
package:
  name: axil_ram

sources:
  # packages first, then the interface and the RTL
  - axil_pkg.sv
  - mem_pkg.sv
  - mem_port_if.sv
  - axil_slave.sv
  - bram_2rw.sv
  - axil_resp_buffer.sv
  - axil_ram_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_axil_ram.sv
